// File: filelist.f
+incdir+include
verilog/dma_pkg.sv
verilog/dma_cmd_decode.sv
verilog/dma_rd_req_gen.sv
verilog/dma_wr_req_gen.sv
verilog/dma_ctrl_fsm.sv
verilog/dma_fifo.sv
verilog/dma_top.sv
verif/tb_dma.sv

// File: run.sh
#!/bin/sh
# Build and run the DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_dma --Mdir obj_dir

# The exit status of the pipe is tee's, the log search decides
./obj_dir/Vtb_dma | tee sim.log

grep -q "Regression passed" sim.log
echo "Simulation log has the pass line"

// File: verif/tb_dma.sv
// --------------------
// DMA engine testbench
// Drives bad and random copy commands into the DMA core,
// models AXI read and write memory, and checks copies,
// burst sizing, credits and error handling
// --------------------
`include "dma_macros.svh"

module tb_dma;

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_BAD         = 7;
    localparam int NUM_GOOD        = 20;
    localparam int MAX_BYTES       = 512;
    localparam int CYCLES_PER_BYTE = 8;
    localparam int BLOCK_CHOICES [8] = '{0, 4, 8, 16, 32, 64, 128, 16};

    // DUT inputs, all start at a known value
    logic                clk             = 1'b0;
    logic                rst_n           = 1'b0;
    logic                go_i            = 1'b0;
    dma_pkg::addr_t      src_addr_i      = '0;
    dma_pkg::addr_t      dst_addr_i      = '0;
    dma_pkg::xfer_len_t  byte_count_i    = '0;
    dma_pkg::xfer_len_t  block_size_i    = '0;
    logic                flush_i         = 1'b0;
    logic                rd_req_ready_i  = 1'b0;
    logic                wr_req_ready_i  = 1'b0;
    logic                r_valid_i       = 1'b0;
    dma_pkg::data_t      r_data_i        = '0;
    logic                w_ready_i       = 1'b0;
    logic                rd_resp_valid_i = 1'b0;
    dma_pkg::resp_t      rd_resp_i       = '0;
    logic                wr_resp_valid_i = 1'b0;
    dma_pkg::resp_t      wr_resp_i       = '0;

    logic                busy_o;
    logic                done_o;
    logic                error_o;
    logic                rd_req_valid_o;
    dma_pkg::addr_t      rd_req_addr_o;
    dma_pkg::burst_len_t rd_req_len_o;
    logic                wr_req_valid_o;
    dma_pkg::addr_t      wr_req_addr_o;
    dma_pkg::burst_len_t wr_req_len_o;
    logic                r_ready_o;
    logic                w_valid_o;
    dma_pkg::data_t      w_data_o;

    // Current command as the checks expect it
    dma_pkg::addr_t      cmd_src    = '0;
    dma_pkg::addr_t      cmd_dst    = '0;
    int                  cmd_blk    = `DMA_MAX_BLOCK_BYTES;
    logic                bad_cmd    = 1'b0;
    logic                inject_err = 1'b0;

    // Traffic counters, cleared on go
    int                  rd_bytes_req = 0;
    int                  wr_bytes_req = 0;
    int                  words_pushed = 0;
    int                  words_popped = 0;
    int                  wr_reqs      = 0;
    int                  wr_resps     = 0;
    dma_pkg::data_t      dst_mem [dma_pkg::addr_t];

    // Memory model state
    dma_pkg::addr_t      rd_q_addr [$];
    int                  rd_q_beats [$];
    int                  rd_beat     = 0;
    int                  rd_resp_cnt = 0;
    logic [31:0]         rd_rng      = 32'h764d ^ 32'h5a5a_0000;
    int                  wr_q [$];
    int                  wr_req_end  = 0;
    int                  wr_data_end = 0;
    int                  gap         = 0;
    logic [31:0]         wr_rng      = 32'h764d ^ 32'h00c3_3c00;

    dma_top dut (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Source memory content, a hash of the full byte address
    function automatic dma_pkg::data_t src_word(input dma_pkg::addr_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h6a09_e667;
    endfunction

    function automatic int expected_block(input dma_pkg::xfer_len_t bs);
        if ((bs == 32'd0) || (bs > `DMA_MAX_BLOCK_BYTES)) begin
            return `DMA_MAX_BLOCK_BYTES;
        end
        return int'(bs);
    endfunction

    function automatic bit burst_ok(input dma_pkg::addr_t addr, input dma_pkg::burst_len_t len,
                                    input dma_pkg::addr_t exp_addr, input int blk);
        int             bytes;
        dma_pkg::addr_t last;
        bytes = int'(len) + `DMA_BYTES_PER_WORD;
        last  = addr + dma_pkg::addr_t'(bytes - 1);
        return (addr == exp_addr) && (bytes <= blk) &&
               ((addr / dma_pkg::addr_t'(blk)) == (last / dma_pkg::addr_t'(blk)));
    endfunction

    function automatic bit copy_matches(input int words);
        dma_pkg::addr_t waddr;
        for (int i = 0; i < words; i++) begin
            waddr = cmd_dst + dma_pkg::addr_t'(4 * i);
            if (!dst_mem.exists(waddr)) begin
                return 1'b0;
            end
            if (dst_mem[waddr] != src_word(cmd_src + dma_pkg::addr_t'(4 * i))) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at time %0t: %s", $time, msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_quiet(input string when_s);
        assert (!busy_o && !done_o && !error_o && !rd_req_valid_o && !wr_req_valid_o &&
                !w_valid_o && !r_ready_o)
        else report_mismatch({"control outputs not low ", when_s});
    endtask

    // Counts traffic per command and collects write beats
    always @(posedge clk) begin
        if (go_i) begin
            rd_bytes_req <= 0;
            wr_bytes_req <= 0;
            words_pushed <= 0;
            words_popped <= 0;
            wr_reqs      <= 0;
            wr_resps     <= 0;
            dst_mem.delete();
        end else begin
            if (rd_req_valid_o && rd_req_ready_i) begin
                rd_bytes_req <= rd_bytes_req + int'(rd_req_len_o) + `DMA_BYTES_PER_WORD;
            end
            if (wr_req_valid_o && wr_req_ready_i) begin
                wr_bytes_req <= wr_bytes_req + int'(wr_req_len_o) + `DMA_BYTES_PER_WORD;
                wr_reqs      <= wr_reqs + 1;
            end
            if (r_valid_i && r_ready_o) begin
                words_pushed <= words_pushed + 1;
            end
            if (w_valid_o && w_ready_i) begin
                dst_mem[cmd_dst + dma_pkg::addr_t'(4 * words_popped)] = w_data_o;
                words_popped <= words_popped + 1;
            end
            if (wr_resp_valid_i) begin
                wr_resps <= wr_resps + 1;
            end
        end
    end

    // Read memory, answers requests in order
    always @(posedge clk) begin
        if (!rst_n) begin
            r_valid_i       <= 1'b0;
            rd_req_ready_i  <= 1'b0;
            rd_resp_valid_i <= 1'b0;
            rd_q_addr.delete();
            rd_q_beats.delete();
            rd_beat = 0;
        end else begin
            rd_resp_valid_i <= 1'b0;
            if (go_i) begin
                rd_resp_cnt = 0;
            end
            if (rd_req_valid_o && rd_req_ready_i) begin
                rd_q_addr.push_back(rd_req_addr_o);
                rd_q_beats.push_back((int'(rd_req_len_o) + `DMA_BYTES_PER_WORD) / 4);
            end
            if (r_valid_i && r_ready_o) begin
                rd_beat++;
                if (rd_beat == rd_q_beats[0]) begin
                    rd_resp_valid_i <= 1'b1;
                    rd_resp_i <= (inject_err && (rd_resp_cnt == 0)) ? `AXI_RESP_SLVERR : 2'b00;
                    rd_resp_cnt++;
                    rd_beat = 0;
                    void'(rd_q_addr.pop_front());
                    void'(rd_q_beats.pop_front());
                end
            end
            rd_rng = xorshift(rd_rng);
            rd_req_ready_i <= (rd_rng[3:0] != 4'd0);
            // Hold a beat that was not taken
            if (!(r_valid_i && !r_ready_o)) begin
                if ((rd_q_addr.size() != 0) && (rd_rng[7:6] != 2'b00)) begin
                    r_valid_i <= 1'b1;
                    r_data_i  <= src_word(rd_q_addr[0] + dma_pkg::addr_t'(4 * rd_beat));
                end else begin
                    r_valid_i <= 1'b0;
                end
            end
        end
    end

    // Write memory, one response per request once its beats are in
    always @(posedge clk) begin
        if (!rst_n) begin
            w_ready_i       <= 1'b0;
            wr_req_ready_i  <= 1'b0;
            wr_resp_valid_i <= 1'b0;
            wr_q.delete();
            gap = 0;
        end else begin
            wr_resp_valid_i <= 1'b0;
            wr_req_ready_i  <= 1'b1;
            if (go_i) begin
                wr_req_end  = 0;
                wr_data_end = 0;
            end
            if (wr_req_valid_o && wr_req_ready_i) begin
                wr_req_end += int'(wr_req_len_o) + `DMA_BYTES_PER_WORD;
                wr_q.push_back(wr_req_end);
            end
            if (w_valid_o && w_ready_i) begin
                wr_data_end += `DMA_BYTES_PER_WORD;
            end
            wr_rng = xorshift(wr_rng);
            if ((wr_q.size() != 0) && (wr_q[0] <= wr_data_end) && (wr_rng[1:0] == 2'b00)) begin
                wr_resp_valid_i <= 1'b1;
                wr_resp_i       <= 2'b00;
                void'(wr_q.pop_front());
            end
            // Long stalls on the write data channel
            if (gap != 0) begin
                gap--;
                w_ready_i <= 1'b0;
            end else if (wr_rng[7:4] == 4'd0) begin
                gap = int'(wr_rng[12:8]);
                w_ready_i <= 1'b0;
            end else begin
                w_ready_i <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (rd_req_valid_o && rd_req_ready_i) |->
        burst_ok(rd_req_addr_o, rd_req_len_o, cmd_src + dma_pkg::addr_t'(rd_bytes_req), cmd_blk))
        else report_mismatch("read burst has a wrong address, size or block crossing");

    assert property (@(posedge clk) disable iff (!rst_n)
        (wr_req_valid_o && wr_req_ready_i) |->
        burst_ok(wr_req_addr_o, wr_req_len_o, cmd_dst + dma_pkg::addr_t'(wr_bytes_req), cmd_blk))
        else report_mismatch("write burst has a wrong address, size or block crossing");

    assert property (@(posedge clk) disable iff (!rst_n) bad_cmd |-> !rd_req_valid_o)
        else report_mismatch("read request issued for a bad command");

    assert property (@(posedge clk) disable iff (!rst_n)
        (rd_bytes_req / 4 - words_popped) <= `DMA_FIFO_WORDS)
        else report_mismatch("read words in flight exceed the FIFO depth");

    assert property (@(posedge clk) disable iff (!rst_n) (wr_bytes_req / 4) <= words_pushed)
        else report_mismatch("write requests exceed the words received");

    assert property (@(posedge clk) disable iff (!rst_n)
        (wr_reqs - wr_resps) <= `DMA_WR_RESP_MAX)
        else report_mismatch("too many pending write responses");

    assert property (@(posedge clk) disable iff (!rst_n) done_o |=> !done_o)
        else report_mismatch("done_o high for more than one cycle");

    task automatic run_cmd(input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
                           input dma_pkg::xfer_len_t cnt, input dma_pkg::xfer_len_t bs,
                           input bit bad, input bit inject);
        @(posedge clk);
        go_i         <= 1'b1;
        src_addr_i   <= src;
        dst_addr_i   <= dst;
        byte_count_i <= cnt;
        block_size_i <= bs;
        cmd_src      <= src;
        cmd_dst      <= dst;
        cmd_blk      <= expected_block(bs);
        bad_cmd      <= bad;
        inject_err   <= inject;
        @(posedge clk);
        go_i <= 1'b0;
        @(negedge clk);
        while (!done_o && !error_o) begin
            @(negedge clk);
        end
        if (bad || inject) begin
            assert (error_o && !done_o) else report_mismatch("expected error_o and no done_o");
        end else begin
            assert (done_o) else report_mismatch("expected done_o at the end of the copy");
        end
        if (bad) begin
            assert (rd_bytes_req == 0) else report_mismatch("bad command moved data");
        end else begin
            assert ((rd_bytes_req == int'(cnt)) && (wr_bytes_req == int'(cnt)))
            else report_mismatch("burst lengths do not add up to the byte count");
            assert (copy_matches(int'(cnt) / 4))
            else report_mismatch("destination data differs from the source pattern");
        end
        if (error_o) begin
            @(posedge clk);
            flush_i <= 1'b1;
            @(posedge clk);
            flush_i <= 1'b0;
            @(negedge clk);
            assert (!busy_o) else report_mismatch("busy_o still high after flush");
        end
    endtask

    initial begin
        logic [31:0]        rng;
        dma_pkg::xfer_len_t cnt;
        dma_pkg::xfer_len_t bs;
        dma_pkg::addr_t     src;
        dma_pkg::addr_t     dst;
        rng = 32'h764d;
        repeat (4) begin
            @(negedge clk);
            check_quiet("during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_quiet("after reset");

        // Illegal commands
        run_cmd(32'h1000_0000, 32'h2000_0000, 32'd0, 32'd0, 1'b1, 1'b0);
        run_cmd(32'h1000_0000, 32'h2000_0000, 32'd6, 32'd0, 1'b1, 1'b0);
        run_cmd(32'h1000_0002, 32'h2000_0000, 32'd64, 32'd0, 1'b1, 1'b0);
        run_cmd(32'h1000_0000, 32'h2000_0001, 32'd64, 32'd0, 1'b1, 1'b0);
        run_cmd(32'h1000_0000, 32'h2000_0000, 32'd64, 32'd12, 1'b1, 1'b0);
        run_cmd(32'h1000_0000, 32'h2000_0000, 32'd64, 32'd2, 1'b1, 1'b0);
        run_cmd(32'h1000_0000, 32'h2000_0000, `DMA_MAX_XFER_BYTES + 32'd4, 32'd0, 1'b1, 1'b0);

        // Random copies, one of them with a read SLVERR
        for (int i = 0; i < NUM_GOOD; i++) begin
            rng = xorshift(rng);
            cnt = dma_pkg::xfer_len_t'({rng[6:0], 2'b00}) + 32'd4;
            rng = xorshift(rng);
            bs  = dma_pkg::xfer_len_t'(BLOCK_CHOICES[rng[2:0]]);
            rng = xorshift(rng);
            src = {12'h100, rng[19:2], 2'b00};
            rng = xorshift(rng);
            dst = {12'h200, rng[19:2], 2'b00};
            run_cmd(src, dst, cnt, bs, 1'b0, i == 3);
        end
        $display("Regression passed");
        $finish;
    end

    initial begin
        #((NUM_BAD + NUM_GOOD) * MAX_BYTES * CYCLES_PER_BYTE * CLK_PERIOD);
        $display("Watchdog timeout: the commands did not finish in time");
        $display("Regression failed");
        $fatal(1);
    end

endmodule

// File: verilog/dma_top.sv
// --------------------
// DMA engine top level
// Command decode, read and write request generators,
// control FSM and the data FIFO between AXI read and write
// --------------------
`include "dma_macros.svh"

module dma_top (
    input  logic                clk,
    input  logic                rst_n,
    // Command and status
    input  logic                go_i,
    input  dma_pkg::addr_t      src_addr_i,
    input  dma_pkg::addr_t      dst_addr_i,
    input  dma_pkg::xfer_len_t  byte_count_i,
    input  dma_pkg::xfer_len_t  block_size_i,
    input  logic                flush_i,
    output logic                busy_o,
    output logic                done_o,
    output logic                error_o,
    // Burst requests
    output logic                rd_req_valid_o,
    input  logic                rd_req_ready_i,
    output dma_pkg::addr_t      rd_req_addr_o,
    output dma_pkg::burst_len_t rd_req_len_o,
    output logic                wr_req_valid_o,
    input  logic                wr_req_ready_i,
    output dma_pkg::addr_t      wr_req_addr_o,
    output dma_pkg::burst_len_t wr_req_len_o,
    // Data beats
    input  logic                r_valid_i,
    input  dma_pkg::data_t      r_data_i,
    output logic                r_ready_o,
    output logic                w_valid_o,
    output dma_pkg::data_t      w_data_o,
    input  logic                w_ready_i,
    // Responses
    input  logic                rd_resp_valid_i,
    input  dma_pkg::resp_t      rd_resp_i,
    input  logic                wr_resp_valid_i,
    input  dma_pkg::resp_t      wr_resp_i
);

    dma_pkg::dma_state_e       state;
    dma_pkg::burst_len_t       blk_bytes;
    logic                      cmd_err;
    logic                      fifo_push;
    logic                      fifo_pop;
    logic                      fifo_clr;
    logic [`DMA_WR_PEND_W-1:0] wr_pending;

    assign fifo_push = r_valid_i && r_ready_o;
    assign fifo_pop  = w_valid_o && w_ready_i;
    // Keeps the FIFO empty and closed between transfers
    assign fifo_clr  = (state == dma_pkg::DMA_IDLE);

    dma_cmd_decode u_cmd_decode (
        .src_addr_i  (src_addr_i),
        .dst_addr_i  (dst_addr_i),
        .byte_count_i(byte_count_i),
        .block_size_i(block_size_i),
        .cmd_err_o   (cmd_err),
        .blk_bytes_o (blk_bytes)
    );

    dma_rd_req_gen u_rd_req_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .state_i       (state),
        .src_addr_i    (src_addr_i),
        .byte_count_i  (byte_count_i),
        .blk_bytes_i   (blk_bytes),
        .fifo_pop_i    (fifo_pop),
        .rd_req_valid_o(rd_req_valid_o),
        .rd_req_ready_i(rd_req_ready_i),
        .rd_req_addr_o (rd_req_addr_o),
        .rd_req_len_o  (rd_req_len_o)
    );

    dma_wr_req_gen u_wr_req_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .state_i        (state),
        .dst_addr_i     (dst_addr_i),
        .byte_count_i   (byte_count_i),
        .blk_bytes_i    (blk_bytes),
        .fifo_push_i    (fifo_push),
        .wr_resp_valid_i(wr_resp_valid_i),
        .wr_req_valid_o (wr_req_valid_o),
        .wr_req_ready_i (wr_req_ready_i),
        .wr_req_addr_o  (wr_req_addr_o),
        .wr_req_len_o   (wr_req_len_o),
        .wr_pending_o   (wr_pending)
    );

    dma_ctrl_fsm u_ctrl_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .go_i           (go_i),
        .flush_i        (flush_i),
        .cmd_err_i      (cmd_err),
        .byte_count_i   (byte_count_i),
        .fifo_pop_i     (fifo_pop),
        .wr_pending_i   (wr_pending),
        .rd_resp_valid_i(rd_resp_valid_i),
        .rd_resp_i      (rd_resp_i),
        .wr_resp_valid_i(wr_resp_valid_i),
        .wr_resp_i      (wr_resp_i),
        .state_o        (state),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .error_o        (error_o)
    );

    dma_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .clr_i   (fifo_clr),
        .wvalid_i(r_valid_i),
        .wready_o(r_ready_o),
        .wdata_i (r_data_i),
        .rvalid_o(w_valid_o),
        .rready_i(w_ready_i),
        .rdata_o (w_data_o)
    );

endmodule

// File: verilog/dma_fifo.sv
// --------------------
// DMA data FIFO
// Circular buffer between read data and write data,
// with a synchronous clear
// --------------------
`include "dma_macros.svh"

module dma_fifo (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clr_i,
    input  logic          wvalid_i,
    output logic          wready_o,
    input  dma_pkg::data_t wdata_i,
    output logic          rvalid_o,
    input  logic          rready_i,
    output dma_pkg::data_t rdata_o
);

    localparam int PTR_W = $clog2(`DMA_FIFO_WORDS);

    dma_pkg::data_t   mem [`DMA_FIFO_WORDS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    dma_pkg::credit_t count;
    logic             push;
    logic             pop;

    // Both sides are closed while the clear is held
    assign wready_o = !clr_i && (count != dma_pkg::credit_t'(`DMA_FIFO_WORDS));
    assign rvalid_o = !clr_i && (count != '0);
    assign rdata_o  = mem[rd_ptr];
    assign push     = wvalid_i && wready_o;
    assign pop      = rvalid_o && rready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + dma_pkg::credit_t'(push) - dma_pkg::credit_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

endmodule

// File: verilog/dma_ctrl_fsm.sv
// --------------------
// DMA control FSM
// Sequences a transfer from go to done or error, counts
// bytes still to be written and latches AXI errors
// --------------------
`include "dma_macros.svh"

module dma_ctrl_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      go_i,
    input  logic                      flush_i,
    input  logic                      cmd_err_i,
    input  dma_pkg::xfer_len_t        byte_count_i,
    input  logic                      fifo_pop_i,
    input  logic [`DMA_WR_PEND_W-1:0] wr_pending_i,
    input  logic                      rd_resp_valid_i,
    input  dma_pkg::resp_t            rd_resp_i,
    input  logic                      wr_resp_valid_i,
    input  dma_pkg::resp_t            wr_resp_i,
    output dma_pkg::dma_state_e       state_o,
    output logic                      busy_o,
    output logic                      done_o,
    output logic                      error_o
);

    dma_pkg::dma_state_e state_ns;
    dma_pkg::xfer_len_t  bytes_remaining;
    logic                axi_error;
    logic                rd_resp_err;
    logic                wr_resp_err;
    logic                xfer_end;

    assign rd_resp_err = rd_resp_valid_i && (rd_resp_i inside {`AXI_RESP_SLVERR, `AXI_RESP_DECERR});
    assign wr_resp_err = wr_resp_valid_i && (wr_resp_i inside {`AXI_RESP_SLVERR, `AXI_RESP_DECERR});
    assign xfer_end    = (bytes_remaining == '0) && (wr_pending_i == '0);

    always_comb begin
        state_ns = state_o;
        case (state_o)
            dma_pkg::DMA_IDLE: begin
                if (go_i) begin
                    state_ns = cmd_err_i ? dma_pkg::DMA_ERROR : dma_pkg::DMA_WAIT_DATA;
                end
            end
            dma_pkg::DMA_WAIT_DATA: begin
                if (xfer_end) begin
                    state_ns = axi_error ? dma_pkg::DMA_ERROR : dma_pkg::DMA_DONE;
                end
            end
            dma_pkg::DMA_DONE: state_ns = dma_pkg::DMA_IDLE;
            dma_pkg::DMA_ERROR: begin
                if (flush_i) begin
                    state_ns = dma_pkg::DMA_IDLE;
                end
            end
            default: state_ns = dma_pkg::DMA_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_o         <= dma_pkg::DMA_IDLE;
            bytes_remaining <= '0;
            axi_error       <= 1'b0;
        end else begin
            state_o <= state_ns;
            // Counted at the write side, one word per FIFO pop
            if ((state_o == dma_pkg::DMA_IDLE) && go_i) begin
                bytes_remaining <= byte_count_i;
            end else if (fifo_pop_i) begin
                bytes_remaining <= bytes_remaining - `DMA_BYTES_PER_WORD;
            end
            if ((state_o == dma_pkg::DMA_IDLE) || flush_i) begin
                axi_error <= 1'b0;
            end else if (rd_resp_err || wr_resp_err) begin
                axi_error <= 1'b1;
            end
        end
    end

    assign busy_o  = (state_o != dma_pkg::DMA_IDLE);
    assign done_o  = (state_o == dma_pkg::DMA_DONE);
    assign error_o = (state_o == dma_pkg::DMA_ERROR);

endmodule

// File: verilog/dma_wr_req_gen.sv
// --------------------
// DMA write request generator
// Issues block-bounded write bursts once the FIFO holds
// their data, and tracks outstanding write responses
// --------------------
`include "dma_macros.svh"

module dma_wr_req_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  dma_pkg::dma_state_e      state_i,
    input  dma_pkg::addr_t           dst_addr_i,
    input  dma_pkg::xfer_len_t       byte_count_i,
    input  dma_pkg::burst_len_t      blk_bytes_i,
    input  logic                     fifo_push_i,
    input  logic                     wr_resp_valid_i,
    output logic                     wr_req_valid_o,
    input  logic                     wr_req_ready_i,
    output dma_pkg::addr_t           wr_req_addr_o,
    output dma_pkg::burst_len_t      wr_req_len_o,
    output logic [`DMA_WR_PEND_W-1:0] wr_pending_o
);

    localparam int WORD_LSB = $clog2(`DMA_BYTES_PER_WORD);

    dma_pkg::xfer_len_t  wr_requested;
    dma_pkg::xfer_len_t  wr_remaining;
    dma_pkg::burst_len_t to_boundary;
    dma_pkg::burst_len_t burst_bytes;
    dma_pkg::credit_t    burst_words;
    dma_pkg::credit_t    fill_credits;
    logic                wr_hshake;

    always_comb begin
        wr_remaining  = byte_count_i - wr_requested;
        wr_req_addr_o = dst_addr_i + wr_requested;
        to_boundary   = blk_bytes_i - (dma_pkg::burst_len_t'(wr_req_addr_o) &
                                       (blk_bytes_i - dma_pkg::burst_len_t'(1)));
        if (wr_remaining < dma_pkg::xfer_len_t'(to_boundary)) begin
            burst_bytes = dma_pkg::burst_len_t'(wr_remaining);
        end else begin
            burst_bytes = to_boundary;
        end
        burst_words   = dma_pkg::credit_t'(burst_bytes[`DMA_BURST_LEN_W-1:WORD_LSB]);
    end

    // Stall while the response counter is saturated
    assign wr_req_len_o   = burst_bytes - dma_pkg::burst_len_t'(`DMA_BYTES_PER_WORD);
    assign wr_req_valid_o = (state_i == dma_pkg::DMA_WAIT_DATA) &&
                            (wr_requested < byte_count_i) &&
                            (fill_credits >= burst_words) &&
                            (wr_pending_o != `DMA_WR_PEND_W'(`DMA_WR_RESP_MAX));
    assign wr_hshake      = wr_req_valid_o && wr_req_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_requested <= '0;
            fill_credits <= '0;
            wr_pending_o <= '0;
        end else if (state_i == dma_pkg::DMA_IDLE) begin
            wr_requested <= '0;
            fill_credits <= '0;
            wr_pending_o <= '0;
        end else begin
            if (wr_hshake) begin
                wr_requested <= wr_requested + dma_pkg::xfer_len_t'(burst_bytes);
            end
            fill_credits <= fill_credits + dma_pkg::credit_t'(fifo_push_i) -
                            (wr_hshake ? burst_words : '0);
            // Request and response in one cycle cancel out
            if (wr_hshake && !wr_resp_valid_i) begin
                wr_pending_o <= wr_pending_o + 1'b1;
            end else if (!wr_hshake && wr_resp_valid_i) begin
                wr_pending_o <= wr_pending_o - 1'b1;
            end
        end
    end

endmodule

// File: verilog/dma_rd_req_gen.sv
// --------------------
// DMA read request generator
// Splits the source range into block-bounded bursts and
// holds each one back until the FIFO has room for it
// --------------------
`include "dma_macros.svh"

module dma_rd_req_gen (
    input  logic                clk,
    input  logic                rst_n,
    input  dma_pkg::dma_state_e state_i,
    input  dma_pkg::addr_t      src_addr_i,
    input  dma_pkg::xfer_len_t  byte_count_i,
    input  dma_pkg::burst_len_t blk_bytes_i,
    input  logic                fifo_pop_i,
    output logic                rd_req_valid_o,
    input  logic                rd_req_ready_i,
    output dma_pkg::addr_t      rd_req_addr_o,
    output dma_pkg::burst_len_t rd_req_len_o
);

    localparam int WORD_LSB = $clog2(`DMA_BYTES_PER_WORD);

    dma_pkg::xfer_len_t  rd_requested;
    dma_pkg::xfer_len_t  rd_remaining;
    dma_pkg::burst_len_t to_boundary;
    dma_pkg::burst_len_t burst_bytes;
    dma_pkg::credit_t    burst_words;
    dma_pkg::credit_t    free_credits;
    logic                rd_hshake;

    always_comb begin
        rd_remaining  = byte_count_i - rd_requested;
        rd_req_addr_o = src_addr_i + rd_requested;
        // Bytes left before the next block boundary
        to_boundary   = blk_bytes_i - (dma_pkg::burst_len_t'(rd_req_addr_o) &
                                       (blk_bytes_i - dma_pkg::burst_len_t'(1)));
        if (rd_remaining < dma_pkg::xfer_len_t'(to_boundary)) begin
            burst_bytes = dma_pkg::burst_len_t'(rd_remaining);
        end else begin
            burst_bytes = to_boundary;
        end
        burst_words   = dma_pkg::credit_t'(burst_bytes[`DMA_BURST_LEN_W-1:WORD_LSB]);
    end

    assign rd_req_len_o   = burst_bytes - dma_pkg::burst_len_t'(`DMA_BYTES_PER_WORD);
    assign rd_req_valid_o = (state_i == dma_pkg::DMA_WAIT_DATA) &&
                            (rd_requested < byte_count_i) &&
                            (free_credits >= burst_words);
    assign rd_hshake      = rd_req_valid_o && rd_req_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_requested <= '0;
            free_credits <= dma_pkg::credit_t'(`DMA_FIFO_WORDS);
        end else if (state_i == dma_pkg::DMA_IDLE) begin
            rd_requested <= '0;
            free_credits <= dma_pkg::credit_t'(`DMA_FIFO_WORDS);
        end else begin
            if (rd_hshake) begin
                rd_requested <= rd_requested + dma_pkg::xfer_len_t'(burst_bytes);
            end
            // A slot comes back each time the write side drains a word
            free_credits <= free_credits + dma_pkg::credit_t'(fifo_pop_i) -
                            (rd_hshake ? burst_words : '0);
        end
    end

endmodule

// File: verilog/dma_cmd_decode.sv
// --------------------
// DMA command decode
// Flags illegal commands and picks the block size used
// to split a transfer into bursts
// --------------------
`include "dma_macros.svh"

module dma_cmd_decode (
    input  dma_pkg::addr_t      src_addr_i,
    input  dma_pkg::addr_t      dst_addr_i,
    input  dma_pkg::xfer_len_t  byte_count_i,
    input  dma_pkg::xfer_len_t  block_size_i,
    output logic                cmd_err_o,
    output dma_pkg::burst_len_t blk_bytes_o
);

    localparam int WORD_LSB = $clog2(`DMA_BYTES_PER_WORD);

    logic inv_byte_count;
    logic inv_block_size;
    logic inv_addr;

    always_comb begin
        inv_byte_count = (byte_count_i == '0) ||
                         (|byte_count_i[WORD_LSB-1:0]) ||
                         (byte_count_i > `DMA_MAX_XFER_BYTES);
        // Zero block size means "use the largest block"
        inv_block_size = (block_size_i != '0) &&
                         ((|(block_size_i & (block_size_i - dma_pkg::xfer_len_t'(1)))) ||
                          (|block_size_i[WORD_LSB-1:0]));
        inv_addr       = (|src_addr_i[WORD_LSB-1:0]) || (|dst_addr_i[WORD_LSB-1:0]);
    end

    assign cmd_err_o = inv_byte_count || inv_block_size || inv_addr;

    // Blocks larger than half the FIFO are clamped
    always_comb begin
        if ((block_size_i != '0) && (block_size_i <= `DMA_MAX_BLOCK_BYTES)) begin
            blk_bytes_o = dma_pkg::burst_len_t'(block_size_i);
        end else begin
            blk_bytes_o = dma_pkg::burst_len_t'(`DMA_MAX_BLOCK_BYTES);
        end
    end

endmodule

// File: verilog/dma_pkg.sv
// --------------------
// DMA package
// Vector types and the control state encoding
// --------------------
`include "dma_macros.svh"

package dma_pkg;

    // Byte address and one data beat
    typedef logic [`DMA_ADDR_W-1:0] addr_t;
    typedef logic [`DMA_DATA_W-1:0] data_t;

    // Byte count of a whole transfer
    typedef logic [31:0] xfer_len_t;

    // Byte count of one burst, up to the largest block
    typedef logic [`DMA_BURST_LEN_W-1:0] burst_len_t;

    // FIFO word count, 0 up to the full depth
    typedef logic [`DMA_CREDIT_W-1:0] credit_t;

    typedef logic [1:0] resp_t;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_WAIT_DATA,
        DMA_DONE,
        DMA_ERROR
    } dma_state_e;

endpackage

// File: include/dma_macros.svh
// --------------------
// DMA engine constants
// Widths, FIFO depth, burst limits and AXI response codes
// --------------------
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

`define DMA_DATA_W          32
`define DMA_ADDR_W          32
`define DMA_BYTES_PER_WORD  4
`define DMA_FIFO_WORDS      32
// Half the FIFO, so one burst drains while the next one fills
`define DMA_MAX_BLOCK_BYTES 64
`define DMA_MAX_XFER_BYTES  32'h0010_0000
`define DMA_WR_RESP_MAX     15
`define DMA_BURST_LEN_W     7
`define DMA_CREDIT_W        6
`define DMA_WR_PEND_W       4

`define AXI_RESP_SLVERR     2'b10
`define AXI_RESP_DECERR     2'b11

`endif
